/* Makefile */
# Verilator simulation of the fdsu control block

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --timescale 1ns/1ps -f sim.f \
		--top-module tb_fdsu_ctrl -o sim_fdsu
	@out=$$(./obj_dir/sim_fdsu); echo "$$out"; \
		echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

/* logic/fdiv_result_pipe.sv */
//======================================================================
// result pipe
// EX3 and EX4 valid stages after SRT, EX3 requests the write-back
// port, EX4 reports completion to the sequencer
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module fdiv_result_pipe (
  input  wire logic srt_sm_clk,
  input  wire logic cpurst_b,
  input  wire logic flush,
  input  wire logic ex2_pipedown,
  output logic      inst_wb_req,
  output logic      ex4_done
);

  logic ex3_vld;
  logic ex4_vld;

  // one item per stage, no stall
  always_ff @(posedge srt_sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      ex3_vld <= 1'b0;
      ex4_vld <= 1'b0;
    end
    else if (flush)
    begin
      ex3_vld <= 1'b0;
      ex4_vld <= 1'b0;
    end
    else
    begin
      ex3_vld <= ex2_pipedown;
      ex4_vld <= ex3_vld;
    end
  end

  // write-back port request
  assign inst_wb_req = ex3_vld;
  // write-back done two cycles after EX2
  assign ex4_done    = ex4_vld;

endmodule : fdiv_result_pipe

`default_nettype wire

/* logic/fdiv_seq_fsm.sv */
//======================================================================
// divide sequencer
// accepts the issue, launches SRT from EX1, waits in EX2 for the last
// round and in WB_REQ for write-back completion, then signals the
// valid instruction in WB
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module fdiv_seq_fsm
  import fdsu_ctrl_pkg::*;
(
  input  wire logic srt_sm_clk,
  input  wire logic cpurst_b,
  input  wire logic flush,
  input  wire logic issue,
  input  wire logic ex1_sel,
  input  wire logic ex4_done,
  srt_round_if.seq  round,
  output logic      launch,
  output logic      ex2_pipedown,
  output logic      inst_vld,
  output logic      fdiv_busy,
  output logic      div_idle
);

  logic [seq_w-1:0] cur_state;
  logic [seq_w-1:0] nxt_state;

  //====================================================================
  // state register
  //====================================================================
  // flush wins over any transition
  always_ff @(posedge srt_sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      cur_state <= st_idle;
    end
    else if (flush)
    begin
      cur_state <= st_idle;
    end
    else
    begin
      cur_state <= nxt_state;
    end
  end

  //====================================================================
  // next state
  //====================================================================
  always_comb
  begin
    nxt_state = st_idle;
    case (cur_state)
      // issue only sampled here and in WB
      st_idle:
      begin
        if (issue)
          nxt_state = st_rf;
        else
          nxt_state = st_idle;
      end
      // operand read, always one cycle
      st_rf:
      begin
        nxt_state = st_ex1;
      end
      // pipe select low cancels the op
      st_ex1:
      begin
        if (ex1_sel)
          nxt_state = st_ex2;
        else
          nxt_state = st_idle;
      end
      // hold while SRT iterates
      st_ex2:
      begin
        if (round.last_round)
          nxt_state = st_wb_req;
        else
          nxt_state = st_ex2;
      end
      // wait for result pipe to drain
      st_wb_req:
      begin
        if (ex4_done)
          nxt_state = st_wb;
        else
          nxt_state = st_wb_req;
      end
      // back-to-back issue skips IDLE
      st_wb:
      begin
        if (issue)
          nxt_state = st_rf;
        else
          nxt_state = st_idle;
      end
      default:
      begin
        nxt_state = st_idle;
      end
    endcase
  end

  //====================================================================
  // outputs
  //====================================================================
  // ex1 pipedown, qualified by the state
  assign launch       = (cur_state == st_ex1) && ex1_sel;

  // leave EX2 with the last SRT round
  assign ex2_pipedown = (cur_state == st_ex2) && round.last_round;

  assign inst_vld     = (cur_state == st_wb);

  // RF through WB_REQ
  assign fdiv_busy    = cur_state[2];
  assign div_idle     = (cur_state == st_idle);

endmodule : fdiv_seq_fsm

`default_nettype wire

/* logic/fdsu_ctrl.sv */
//======================================================================
// fdsu control top
// divide and square-root control: sequencer, SRT iteration control
// and result pipe, all on the SRT state machine clock
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module fdsu_ctrl
  import fdsu_ctrl_pkg::*;
(
  input  wire logic              srt_sm_clk,
  input  wire logic              cpurst_b,
  input  wire logic              flush,
  input  wire logic              issue,
  input  wire logic              ex1_sel,
  input  wire logic [prec_w-1:0] prec,
  input  wire logic              rem_zero,
  input  wire logic              skip_srt,
  output logic                   ex1_pipedown,
  output logic                   srt_sm_on,
  output logic                   srt_first_round,
  output logic                   srt_secd_round,
  output logic                   ex2_pipedown,
  output logic                   inst_wb_req,
  output logic                   inst_vld,
  output logic                   fdiv_busy,
  output logic                   div_idle
);

  logic launch;
  logic ex4_done;

  srt_round_if round_if ();

  //====================================================================
  // sequencer
  //====================================================================
  fdiv_seq_fsm x_seq (
    .srt_sm_clk   (srt_sm_clk),
    .cpurst_b     (cpurst_b),
    .flush        (flush),
    .issue        (issue),
    .ex1_sel      (ex1_sel),
    .ex4_done     (ex4_done),
    .round        (round_if.seq),
    .launch       (launch),
    .ex2_pipedown (ex2_pipedown),
    .inst_vld     (inst_vld),
    .fdiv_busy    (fdiv_busy),
    .div_idle     (div_idle)
  );

  //====================================================================
  // SRT iteration
  //====================================================================
  srt_round_ctrl x_srt (
    .srt_sm_clk (srt_sm_clk),
    .cpurst_b   (cpurst_b),
    .flush      (flush),
    .launch     (launch),
    .prec       (prec),
    .rem_zero   (rem_zero),
    .skip_srt   (skip_srt),
    .round      (round_if.ctrl)
  );

  // result pipe, EX3/EX4
  fdiv_result_pipe x_pipe (
    .srt_sm_clk   (srt_sm_clk),
    .cpurst_b     (cpurst_b),
    .flush        (flush),
    .ex2_pipedown (ex2_pipedown),
    .inst_wb_req  (inst_wb_req),
    .ex4_done     (ex4_done)
  );

  // launch doubles as ex1 pipedown toward the datapath
  assign ex1_pipedown    = launch;
  assign srt_sm_on       = round_if.srt_on;
  assign srt_first_round = round_if.first_round;
  assign srt_secd_round  = round_if.secd_round;

endmodule : fdsu_ctrl

`default_nettype wire

/* logic/fdsu_ctrl_pkg.sv */
//======================================================================
// fdsu control package
// state codes of the divide sequencer, precision codes and the
// start values of the SRT round counter per precision
//======================================================================
`default_nettype none

package fdsu_ctrl_pkg;

  //====================================================================
  // SRT round counter
  //====================================================================
  localparam int srt_cnt_w = 5;

  // start value, the full-length round count is start value plus one
  localparam logic [srt_cnt_w-1:0] srt_init_double = 5'd13;
  localparam logic [srt_cnt_w-1:0] srt_init_single = 5'd6;
  localparam logic [srt_cnt_w-1:0] srt_init_half   = 5'd3;
  localparam logic [srt_cnt_w-1:0] srt_init_bfloat = 5'd2;

  //====================================================================
  // precision code
  //====================================================================
  localparam int prec_w = 2;

  localparam logic [prec_w-1:0] prec_double = 2'd0;
  localparam logic [prec_w-1:0] prec_single = 2'd1;
  localparam logic [prec_w-1:0] prec_half   = 2'd2;
  localparam logic [prec_w-1:0] prec_bfloat = 2'd3;

  //====================================================================
  // sequencer state
  //====================================================================
  localparam int seq_w = 4;

  // bit 2 set in every busy state
  localparam logic [seq_w-1:0] st_idle   = 4'b0000;
  localparam logic [seq_w-1:0] st_rf     = 4'b0100;
  localparam logic [seq_w-1:0] st_ex1    = 4'b0101;
  localparam logic [seq_w-1:0] st_ex2    = 4'b0110;
  localparam logic [seq_w-1:0] st_wb_req = 4'b0111;
  localparam logic [seq_w-1:0] st_wb     = 4'b1000;

endpackage : fdsu_ctrl_pkg

`default_nettype wire

/* logic/srt_round_ctrl.sv */
//======================================================================
// SRT iteration control
// busy state, precision dependent round counter, first and second
// round flags and last round detection with early termination
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module srt_round_ctrl
  import fdsu_ctrl_pkg::*;
(
  input  wire logic              srt_sm_clk,
  input  wire logic              cpurst_b,
  input  wire logic              flush,
  input  wire logic              launch,
  input  wire logic [prec_w-1:0] prec,
  input  wire logic              rem_zero,
  input  wire logic              skip_srt,
  srt_round_if.ctrl              round
);

  logic                 srt_busy;
  logic [prec_w-1:0]    prec_q;
  logic [srt_cnt_w-1:0] srt_cnt;
  logic                 cnt_zero;
  logic                 secd_pre;
  logic                 first_q;
  logic                 secd_q;

  // start value per precision
  function automatic logic [srt_cnt_w-1:0] cnt_init(input logic [prec_w-1:0] p);
    logic [srt_cnt_w-1:0] v;
    case (p)
      prec_double: v = srt_init_double;
      prec_single: v = srt_init_single;
      prec_half:   v = srt_init_half;
      default:     v = srt_init_bfloat;
    endcase
    return v;
  endfunction

  //====================================================================
  // busy state
  //====================================================================
  // idle -> busy on launch, busy -> idle after last round
  always_ff @(posedge srt_sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      srt_busy <= 1'b0;
    else if (flush)
      srt_busy <= 1'b0;
    else if (!srt_busy && launch)
      srt_busy <= 1'b1;
    else if (srt_busy && round.last_round)
      srt_busy <= 1'b0;
  end

  // precision held for the whole iteration
  always_ff @(posedge srt_sm_clk)
  begin
    if (launch)
      prec_q <= prec;
  end

  //====================================================================
  // round counter
  //====================================================================
  always_ff @(posedge srt_sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      srt_cnt <= '0;
    else if (flush)
      srt_cnt <= '0;
    else if (launch)
      srt_cnt <= cnt_init(prec);
    else if (srt_busy)
      srt_cnt <= srt_cnt - 1'b1;
  end

  assign cnt_zero = (srt_cnt == '0);

  // counter expiry, zero remainder or no SRT needed
  assign round.last_round = (cnt_zero || rem_zero || skip_srt) && srt_busy;

  //====================================================================
  // round flags
  //====================================================================
  // counter still at start value, and more rounds follow
  assign secd_pre = srt_busy && (srt_cnt == cnt_init(prec_q)) && !round.last_round;

  always_ff @(posedge srt_sm_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      first_q <= 1'b0;
      secd_q  <= 1'b0;
    end
    else if (flush)
    begin
      first_q <= 1'b0;
      secd_q  <= 1'b0;
    end
    else
    begin
      first_q <= launch;
      secd_q  <= secd_pre;
    end
  end

  assign round.srt_on      = srt_busy;
  assign round.first_round = first_q;
  assign round.secd_round  = secd_q;

endmodule : srt_round_ctrl

`default_nettype wire

/* logic/srt_round_if.sv */
//======================================================================
// SRT round status
// busy and round position flags from the SRT iteration control
//======================================================================
`timescale 1ns/1ps
`default_nettype none

interface srt_round_if;

  // SRT iteration running
  logic srt_on;
  // first and second busy cycle
  logic first_round;
  logic secd_round;
  // current busy cycle is the final one
  logic last_round;

  // driven by the iteration control
  modport ctrl (
    output srt_on,
    output first_round,
    output secd_round,
    output last_round
  );

  // sequencer only waits on the last round
  modport seq (
    input  last_round
  );

endinterface : srt_round_if

`default_nettype wire

/* sim.f */
logic/fdsu_ctrl_pkg.sv
logic/srt_round_if.sv
logic/fdiv_seq_fsm.sv
logic/srt_round_ctrl.sv
logic/fdiv_result_pipe.sv
logic/fdsu_ctrl.sv
testbench/tb_fdsu_ctrl.sv

/* testbench/tb_fdsu_ctrl.sv */
//======================================================================
// fdsu control testbench
// runs full-length, early-terminated, skipped, cancelled, flushed and
// back-to-back operations and checks every control output per cycle
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_fdsu_ctrl
  import fdsu_ctrl_pkg::*;
();

  localparam int clk_period = 4;
  localparam int num_tests  = 14;
  localparam int max_ops    = 32;
  localparam int no_flush   = 32'h7fffffff;

  logic              srt_sm_clk;
  logic              cpurst_b;
  logic              flush;
  logic              issue;
  logic              ex1_sel;
  logic [prec_w-1:0] prec;
  logic              rem_zero;
  logic              skip_srt;
  logic              ex1_pipedown;
  logic              srt_sm_on;
  logic              srt_first_round;
  logic              srt_secd_round;
  logic              ex2_pipedown;
  logic              inst_wb_req;
  logic              inst_vld;
  logic              fdiv_busy;
  logic              div_idle;

  int         seed = 32'h020c328a;
  int         cyc = 0;
  int         err_cnt = 0;
  int         chk_cnt = 0;
  logic       checking = 1'b0;
  string      cur_test = "reset";
  logic [8:0] exp_v;

  // issued operations with one schedule each
  int   op_cnt = 0;
  int   op_t0 [max_ops];
  int   op_n [max_ops];
  int   op_flush [max_ops];
  logic op_cancel [max_ops];

  fdsu_ctrl fdsu_ctrl_i (
    .srt_sm_clk      (srt_sm_clk),
    .cpurst_b        (cpurst_b),
    .flush           (flush),
    .issue           (issue),
    .ex1_sel         (ex1_sel),
    .prec            (prec),
    .rem_zero        (rem_zero),
    .skip_srt        (skip_srt),
    .ex1_pipedown    (ex1_pipedown),
    .srt_sm_on       (srt_sm_on),
    .srt_first_round (srt_first_round),
    .srt_secd_round  (srt_secd_round),
    .ex2_pipedown    (ex2_pipedown),
    .inst_wb_req     (inst_wb_req),
    .inst_vld        (inst_vld),
    .fdiv_busy       (fdiv_busy),
    .div_idle        (div_idle)
  );

  initial
  begin
    srt_sm_clk = 1'b0;
  end

  always #(clk_period / 2) srt_sm_clk = ~srt_sm_clk;

  // cycle index stable between edges
  always @(posedge srt_sm_clk)
  begin
    cyc <= cyc + 1;
  end

  //====================================================================
  // reference model
  //====================================================================
  // full-length SRT rounds per precision
  function automatic int round_count(input logic [prec_w-1:0] p);
    case (p)
      prec_double: return 14;
      prec_single: return 7;
      prec_half:   return 4;
      default:     return 3;
    endcase
  endfunction

  // expected outputs in cycle c as OR over all scheduled ops
  // bit order is ex1_pd, srt_on, first, secd, ex2_pd, wb_req, vld, busy, idle
  function automatic logic [8:0] expect_at(input int c);
    logic [8:0] e;
    logic       occ;
    int         i;
    int         l;
    int         n;
    e   = '0;
    occ = 1'b0;
    for (i = 0; i < op_cnt; i++)
    begin
      l = op_t0[i] + 2;
      n = op_n[i];
      // nothing survives past a flushed cycle
      if (c <= op_flush[i] && c > op_t0[i])
      begin
        if (op_cancel[i])
        begin
          if (c <= l)
          begin
            occ  = 1'b1;
            e[7] = 1'b1;
          end
        end
        else
        begin
          if (c <= l + n + 3)
            occ = 1'b1;
          if (c <= l + n + 2)
            e[7] = 1'b1;
          e[0] = e[0] | (c == l);
          e[1] = e[1] | (c > l && c <= l + n);
          e[2] = e[2] | (c == l + 1);
          e[3] = e[3] | (c == l + 2 && n >= 2);
          e[4] = e[4] | (c == l + n);
          e[5] = e[5] | (c == l + n + 1);
          e[6] = e[6] | (c == l + n + 3);
        end
      end
    end
    e[8] = !occ;
    return e;
  endfunction

  //====================================================================
  // compare
  //====================================================================
  task automatic compare_sig(input string sig, input logic e, input logic a);
    chk_cnt++;
    if (e !== a)
    begin
      err_cnt++;
      $display("error %s %s at cycle %0d: expected %0b actual %0b",
               cur_test, sig, cyc, e, a);
    end
  endtask

  // sample mid-cycle with inputs settled since edge plus 1 ns
  always @(negedge srt_sm_clk)
  begin
    if (checking)
    begin
      exp_v = expect_at(cyc);
      compare_sig("ex1_pipedown", exp_v[0], ex1_pipedown);
      compare_sig("srt_sm_on", exp_v[1], srt_sm_on);
      compare_sig("srt_first_round", exp_v[2], srt_first_round);
      compare_sig("srt_secd_round", exp_v[3], srt_secd_round);
      compare_sig("ex2_pipedown", exp_v[4], ex2_pipedown);
      compare_sig("inst_wb_req", exp_v[5], inst_wb_req);
      compare_sig("inst_vld", exp_v[6], inst_vld);
      compare_sig("fdiv_busy", exp_v[7], fdiv_busy);
      compare_sig("div_idle", exp_v[8], div_idle);
    end
  end

  //====================================================================
  // stimulus
  //====================================================================
  task automatic idle_cycles(input int m);
    repeat (m)
    begin
      @(posedge srt_sm_clk);
      #1;
      issue    = 1'b0;
      ex1_sel  = 1'b0;
      rem_zero = 1'b0;
      skip_srt = 1'b0;
      flush    = 1'b0;
    end
  endtask

  // one op from the issue cycle to its last cycle
  // term_k is the busy cycle with rem_zero
  // flush_k is the flush cycle counted from EX1
  task automatic run_op(input logic [prec_w-1:0] p, input logic sel, input int term_k,
                        input logic use_skip, input int flush_k);
    int t0;
    int l;
    int n;
    int f;
    int last;
    int c;
    t0 = cyc;
    l  = t0 + 2;
    if (!sel)
      n = 0;
    else if (use_skip)
      n = 1;
    else if (term_k > 0)
      n = term_k;
    else
      n = round_count(p);
    f    = (flush_k > 0) ? l + flush_k : no_flush;
    last = sel ? l + n + 3 : l;
    if (f < last)
      last = f;
    op_t0[op_cnt]     = t0;
    op_n[op_cnt]      = n;
    op_flush[op_cnt]  = f;
    op_cancel[op_cnt] = !sel;
    op_cnt++;
    for (c = t0; c <= last; c++)
    begin
      if (c > t0)
      begin
        @(posedge srt_sm_clk);
        #1;
      end
      issue    = (c == t0);
      // precision only valid in the launch cycle
      prec     = (c == l) ? p : ~p;
      // pipe select held high where the sequencer must ignore it
      ex1_sel  = (c == l) ? sel : 1'b1;
      rem_zero = !use_skip && term_k > 0 && (c == l + term_k);
      // skip held across launch into the first busy cycle
      skip_srt = use_skip && (c == l || c == l + 1);
      flush    = (c == f);
    end
  endtask

  initial
  begin
    int                i;
    int                k;
    int                rnd;
    logic [prec_w-1:0] p;
    cpurst_b = 1'b0;
    flush    = 1'b0;
    issue    = 1'b0;
    ex1_sel  = 1'b0;
    prec     = prec_double;
    rem_zero = 1'b0;
    skip_srt = 1'b0;
    repeat (3) @(posedge srt_sm_clk);
    #1;
    cpurst_b = 1'b1;
    checking = 1'b1;
    idle_cycles(2);

    // full length for every precision
    for (i = 0; i < 4; i++)
    begin
      cur_test = "full_length";
      run_op(prec_w'(i), 1'b1, 0, 1'b0, 0);
      idle_cycles(2);
    end

    // zero remainder in a random busy cycle
    for (i = 0; i < 4; i++)
    begin
      cur_test = "early_term";
      rnd = $random(seed);
      p   = prec_w'(rnd);
      rnd = $random(seed) & 32'h7fffffff;
      k   = 1 + rnd % round_count(p);
      run_op(p, 1'b1, k, 1'b0, 0);
      idle_cycles(2);
    end

    cur_test = "skip_srt";
    run_op(prec_single, 1'b1, 0, 1'b1, 0);
    idle_cycles(2);

    cur_test = "ex1_cancel";
    run_op(prec_half, 1'b0, 0, 1'b0, 0);
    idle_cycles(2);

    // flush three cycles after launch and then a clean op
    cur_test = "flush";
    run_op(prec_double, 1'b1, 0, 1'b0, 3);
    idle_cycles(1);
    cur_test = "after_flush";
    run_op(prec_bfloat, 1'b1, 0, 1'b0, 0);
    idle_cycles(2);

    // second issue in the WB cycle of the first
    cur_test = "back_to_back";
    rnd = $random(seed);
    run_op(prec_w'(rnd), 1'b1, 0, 1'b0, 0);
    rnd = $random(seed);
    run_op(prec_w'(rnd), 1'b1, 0, 1'b0, 0);
    idle_cycles(4);

    checking = 1'b0;
    $display("checks %0d errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  // watchdog at 40 cycles per test plus margin
  initial
  begin
    #((num_tests * 40 + 50) * clk_period);
    $display("timeout: the test sequence did not finish in time");
    $display("test failed");
    $finish;
  end

endmodule : tb_fdsu_ctrl

`default_nettype wire
